// ==== verilog/pcie_phy_pkg.sv ====
`default_nettype none

package pcie_phy_pkg;

  typedef enum logic [2:0] {
    gen1,
    gen2,
    gen3,
    gen4,
    gen5
  } rate_e;

  // filler for unused slots from gen3 on
  localparam logic [7:0] PAD_BYTE_128B = 8'hf7;

  localparam logic [1:0] SYNC_OS   = 2'b10;
  localparam logic [1:0] SYNC_DATA = 2'b01;

  // lane number position inside a training set
  localparam int LANE_NUM_BYTE = 2;
  localparam int BLOCK_BYTES   = 16;

  // bytes per lane per PIPE beat
  function automatic logic [2:0] pipe_bytes(rate_e rate);
    case (rate)
      gen1:       return 3'd1;
      gen2, gen3: return 3'd2;
      default:    return 3'd4;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== verilog/tx_stream_select.sv ====
`default_nettype none

module tx_stream_select #(
  parameter int MAX_WORDS = 16
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [31:0] os_tdata_i,
  input  logic [3:0]  os_tkeep_i,
  input  logic [4:0]  os_tuser_i,
  input  logic        os_tlast_i,
  input  logic        os_tvalid_i,
  output logic        os_tready_o,
  input  logic [31:0] lk_tdata_i,
  input  logic [3:0]  lk_tkeep_i,
  input  logic [3:0]  lk_tuser_i,
  input  logic        lk_tlast_i,
  input  logic        lk_tvalid_i,
  output logic        lk_tready_o,
  output logic [31:0] sel_data_o,
  output logic [3:0]  sel_keep_o,
  output logic [3:0]  sel_k_o,
  output logic        sel_last_o,
  output logic        sel_is_os_o,
  output logic        sel_replace_o,
  output logic        sel_valid_o,
  input  logic        sel_ready_i
);

  localparam int WordW = $clog2(MAX_WORDS + 1);

  logic             en_r;
  logic             pkt_open_r;
  logic             owner_os_r;
  logic [WordW-1:0] word_cnt_r;
  logic             pick_os;
  logic             can_load;
  logic             in_fire;
  logic             in_last;
  logic             cap_last;
  logic             pkt_replace;

  // ordered sets win only when no packet is open
  assign pick_os  = pkt_open_r ? owner_os_r : os_tvalid_i;
  assign can_load = en_r && (!sel_valid_o || sel_ready_i);

  assign os_tready_o = can_load && pick_os;
  assign lk_tready_o = can_load && !pick_os;

  assign in_fire  = pick_os ? (os_tvalid_i && os_tready_o) : (lk_tvalid_i && lk_tready_o);
  assign in_last  = pick_os ? os_tlast_i : lk_tlast_i;
  // cut an overlong packet at the buffer size
  assign cap_last = (word_cnt_r == WordW'(MAX_WORDS - 1));

  // replace request comes with the first word only
  assign pkt_replace = pkt_open_r ? sel_replace_o : (pick_os && os_tuser_i[4]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_r        <= 1'b0;
      pkt_open_r  <= 1'b0;
      owner_os_r  <= 1'b0;
      word_cnt_r  <= '0;
      sel_valid_o <= 1'b0;
    end else begin
      en_r <= 1'b1;
      if (can_load) begin
        sel_valid_o <= in_fire;
      end
      if (in_fire) begin
        pkt_open_r <= !in_last;
        owner_os_r <= pick_os;
        if (in_last || cap_last) begin
          word_cnt_r <= '0;
        end else begin
          word_cnt_r <= word_cnt_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      sel_data_o    <= pick_os ? os_tdata_i : lk_tdata_i;
      sel_keep_o    <= pick_os ? os_tkeep_i : lk_tkeep_i;
      sel_k_o       <= pick_os ? os_tuser_i[3:0] : lk_tuser_i;
      sel_last_o    <= in_last || cap_last;
      sel_is_os_o   <= pick_os;
      sel_replace_o <= pkt_replace;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lane_management.sv ====
`default_nettype none

module lane_management #(
  parameter int MAX_LANES = 4,
  parameter int MAX_WORDS = 16
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [31:0]                    sel_data_i,
  input  logic [3:0]                     sel_keep_i,
  input  logic [3:0]                     sel_k_i,
  input  logic                           sel_last_i,
  input  logic                           sel_is_os_i,
  input  logic                           sel_replace_i,
  input  logic                           sel_valid_i,
  output logic                           sel_ready_o,
  input  pcie_phy_pkg::rate_e            rate_i,
  input  logic [$clog2(MAX_LANES+1)-1:0] num_lanes_i,
  input  logic                           lane_reverse_i,
  output logic [31:0]                    lm_data_o [MAX_LANES],
  output logic [3:0]                     lm_k_o [MAX_LANES],
  output logic [MAX_LANES-1:0]           lm_valid_o,
  output logic                           lm_first_o,
  output logic                           lm_is_os_o,
  output logic [5:0]                     pipe_width_o
);

  import pcie_phy_pkg::*;

  localparam int BufBytes = 4 * MAX_WORDS;
  localparam int LaneW    = $clog2(MAX_LANES + 1);
  localparam int WordW    = $clog2(MAX_WORDS + 1);
  localparam int ByteW    = $clog2(BufBytes + 1);
  localparam int BaseW    = $clog2(BufBytes + 4 * MAX_LANES + 1);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_SEND
  } lm_state_e;

  lm_state_e           state_r;
  logic [7:0]          buf_data_r [BufBytes];
  logic [BufBytes-1:0] buf_k_r;
  logic [WordW-1:0]    word_cnt_r;
  logic [ByteW-1:0]    byte_cnt_r;
  logic [BaseW-1:0]    base_r;
  logic [5:0]          pipe_width_r;
  rate_e               rate_r;
  logic [LaneW-1:0]    lanes_r;
  logic                rev_r;
  logic                is_os_r;
  logic                replace_r;
  logic                in_fire;
  logic                first_word;
  logic                last_beat;
  logic [2:0]          keep_cnt;
  logic [2:0]          lane_bytes;
  logic [BaseW-1:0]    beat_bytes;

  assign sel_ready_o = (state_r == ST_COLLECT);
  assign in_fire     = sel_valid_i && sel_ready_o;
  assign first_word  = (word_cnt_r == '0);

  always_comb begin
    keep_cnt = '0;
    for (int i = 0; i < 4; i++) begin
      keep_cnt = keep_cnt + 3'(sel_keep_i[i]);
    end
  end

  // striped data moves n*W bytes per beat, ordered sets only W
  assign lane_bytes = pipe_bytes(rate_r);
  assign beat_bytes = is_os_r ? BaseW'(lane_bytes) : BaseW'(lanes_r) * BaseW'(lane_bytes);
  assign last_beat  = (base_r + beat_bytes >= BaseW'(byte_cnt_r));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r      <= ST_IDLE;
      word_cnt_r   <= '0;
      byte_cnt_r   <= '0;
      base_r       <= '0;
      pipe_width_r <= {pipe_bytes(gen1), 3'b000};
    end else begin
      case (state_r)
        ST_IDLE: begin
          state_r <= ST_COLLECT;
        end
        ST_COLLECT: begin
          if (in_fire) begin
            word_cnt_r <= word_cnt_r + 1'b1;
            if (first_word) begin
              byte_cnt_r   <= ByteW'(keep_cnt);
              pipe_width_r <= {pipe_bytes(rate_i), 3'b000};
            end else begin
              byte_cnt_r <= byte_cnt_r + ByteW'(keep_cnt);
            end
            if (sel_last_i) begin
              state_r <= ST_SEND;
              base_r  <= '0;
            end
          end
        end
        ST_SEND: begin
          base_r <= base_r + beat_bytes;
          if (last_beat) begin
            state_r    <= ST_COLLECT;
            word_cnt_r <= '0;
          end
        end
        default: begin
          state_r <= ST_IDLE;
        end
      endcase
    end
  end

  // packet buffer and per-packet settings
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      if (first_word) begin
        rate_r    <= rate_i;
        lanes_r   <= num_lanes_i;
        rev_r     <= lane_reverse_i;
        is_os_r   <= sel_is_os_i;
        replace_r <= sel_replace_i;
      end
      if (int'(word_cnt_r) < MAX_WORDS) begin
        for (int i = 0; i < 4; i++) begin
          buf_data_r[4*word_cnt_r+i] <= sel_data_i[8*i+:8];
          buf_k_r[4*word_cnt_r+i]    <= sel_k_i[i];
        end
      end
    end
  end

  always_comb begin : beat_build
    int         pos;
    logic [7:0] pad_byte;
    pos      = 0;
    pad_byte = (rate_r >= gen3) ? PAD_BYTE_128B : 8'h00;
    for (int l = 0; l < MAX_LANES; l++) begin
      lm_data_o[l]  = '0;
      lm_k_o[l]     = '0;
      lm_valid_o[l] = 1'b0;
      if ((state_r == ST_SEND) && (l < int'(lanes_r))) begin
        lm_valid_o[l] = 1'b1;
        for (int s = 0; s < 4; s++) begin
          if (is_os_r) begin
            pos = int'(base_r) + s;
          end else begin
            pos = int'(base_r) + s * int'(lanes_r) + l;
          end
          lm_data_o[l][8*s+:8] = pad_byte;
          if ((s < int'(lane_bytes)) && (pos < int'(byte_cnt_r))) begin
            lm_data_o[l][8*s+:8] = buf_data_r[pos];
            lm_k_o[l][s]         = buf_k_r[pos];
            // lane number is a data symbol
            if (is_os_r && replace_r && (pos == LANE_NUM_BYTE)) begin
              lm_data_o[l][8*s+:8] = rev_r ? 8'(int'(lanes_r) - 1 - l) : 8'(l);
              lm_k_o[l][s]         = 1'b0;
            end
          end
        end
      end
    end
  end

  assign lm_first_o   = (state_r == ST_SEND) && (base_r == '0);
  assign lm_is_os_o   = is_os_r;
  assign pipe_width_o = pipe_width_r;

endmodule

`default_nettype wire

// ==== verilog/lane_tx_output.sv ====
`default_nettype none

module lane_tx_output #(
  parameter int MAX_LANES = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic [31:0]          lm_data_i [MAX_LANES],
  input  logic [3:0]           lm_k_i [MAX_LANES],
  input  logic [MAX_LANES-1:0] lm_valid_i,
  input  logic                 lm_first_i,
  input  logic                 lm_is_os_i,
  input  pcie_phy_pkg::rate_e  rate_i,
  input  logic [5:0]           pipe_width_i,
  output logic [31:0]          lane_data_o [MAX_LANES],
  output logic [3:0]           lane_k_o [MAX_LANES],
  output logic [MAX_LANES-1:0] lane_valid_o,
  output logic [1:0]           sync_header_o [MAX_LANES],
  output logic                 block_start_o
);

  import pcie_phy_pkg::*;

  localparam int OffW = $clog2(BLOCK_BYTES);

  // bytes per lane since packet start, modulo block size
  logic [OffW-1:0] off_r;
  logic [OffW-1:0] off_now;
  logic            hi_rate_r;
  logic            hi_rate;
  logic            beat;
  logic            blk;
  logic [1:0]      hdr;

  assign beat    = |lm_valid_i;
  assign off_now = lm_first_i ? '0 : off_r;
  // rate is taken at the packet's first beat
  assign hi_rate = lm_first_i ? (rate_i >= gen3) : hi_rate_r;
  assign blk     = beat && hi_rate && (off_now == '0);
  assign hdr     = lm_is_os_i ? SYNC_OS : SYNC_DATA;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lane_valid_o  <= '0;
      block_start_o <= 1'b0;
      off_r         <= '0;
      hi_rate_r     <= 1'b0;
    end else begin
      lane_valid_o  <= lm_valid_i;
      block_start_o <= blk;
      if (beat) begin
        off_r     <= off_now + OffW'(pipe_width_i[5:3]);
        hi_rate_r <= hi_rate;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int l = 0; l < MAX_LANES; l++) begin
      lane_data_o[l]   <= lm_data_i[l];
      lane_k_o[l]      <= lm_k_i[l];
      sync_header_o[l] <= (blk && lm_valid_i[l]) ? hdr : 2'b00;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/pcie_tx_lanes.sv ====
`default_nettype none

module pcie_tx_lanes #(
  parameter int MAX_LANES = 4,
  parameter int MAX_WORDS = 16
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [31:0]                    os_tdata_i,
  input  logic [3:0]                     os_tkeep_i,
  input  logic [4:0]                     os_tuser_i,
  input  logic                           os_tlast_i,
  input  logic                           os_tvalid_i,
  output logic                           os_tready_o,
  input  logic [31:0]                    lk_tdata_i,
  input  logic [3:0]                     lk_tkeep_i,
  input  logic [3:0]                     lk_tuser_i,
  input  logic                           lk_tlast_i,
  input  logic                           lk_tvalid_i,
  output logic                           lk_tready_o,
  input  pcie_phy_pkg::rate_e            rate_i,
  input  logic [$clog2(MAX_LANES+1)-1:0] num_lanes_i,
  input  logic                           lane_reverse_i,
  output logic [31:0]                    lane_data_o [MAX_LANES],
  output logic [3:0]                     lane_k_o [MAX_LANES],
  output logic [MAX_LANES-1:0]           lane_valid_o,
  output logic [1:0]                     sync_header_o [MAX_LANES],
  output logic                           block_start_o,
  output logic [5:0]                     pipe_width_o
);

  logic [31:0]          sel_data;
  logic [3:0]           sel_keep;
  logic [3:0]           sel_k;
  logic                 sel_last;
  logic                 sel_is_os;
  logic                 sel_replace;
  logic                 sel_valid;
  logic                 sel_ready;
  logic [31:0]          lm_data [MAX_LANES];
  logic [3:0]           lm_k [MAX_LANES];
  logic [MAX_LANES-1:0] lm_valid;
  logic                 lm_first;
  logic                 lm_is_os;

  tx_stream_select #(
    .MAX_WORDS(MAX_WORDS)
  ) tx_stream_select_i (
    .clk_i, .rst_i,
    .os_tdata_i, .os_tkeep_i, .os_tuser_i, .os_tlast_i, .os_tvalid_i, .os_tready_o,
    .lk_tdata_i, .lk_tkeep_i, .lk_tuser_i, .lk_tlast_i, .lk_tvalid_i, .lk_tready_o,
    .sel_data_o(sel_data), .sel_keep_o(sel_keep), .sel_k_o(sel_k),
    .sel_last_o(sel_last), .sel_is_os_o(sel_is_os), .sel_replace_o(sel_replace),
    .sel_valid_o(sel_valid), .sel_ready_i(sel_ready)
  );

  lane_management #(
    .MAX_LANES(MAX_LANES),
    .MAX_WORDS(MAX_WORDS)
  ) lane_management_i (
    .clk_i, .rst_i,
    .sel_data_i(sel_data), .sel_keep_i(sel_keep), .sel_k_i(sel_k),
    .sel_last_i(sel_last), .sel_is_os_i(sel_is_os), .sel_replace_i(sel_replace),
    .sel_valid_i(sel_valid), .sel_ready_o(sel_ready),
    .rate_i, .num_lanes_i, .lane_reverse_i,
    .lm_data_o(lm_data), .lm_k_o(lm_k), .lm_valid_o(lm_valid),
    .lm_first_o(lm_first), .lm_is_os_o(lm_is_os), .pipe_width_o
  );

  lane_tx_output #(
    .MAX_LANES(MAX_LANES)
  ) lane_tx_output_i (
    .clk_i, .rst_i,
    .lm_data_i(lm_data), .lm_k_i(lm_k), .lm_valid_i(lm_valid),
    .lm_first_i(lm_first), .lm_is_os_i(lm_is_os),
    .rate_i, .pipe_width_i(pipe_width_o),
    .lane_data_o, .lane_k_o, .lane_valid_o, .sync_header_o, .block_start_o
  );

endmodule

`default_nettype wire

// ==== sim/pcie_tx_lanes_sva.sv ====
`default_nettype none

module pcie_tx_lanes_sva #(
  parameter int MAX_LANES = 4,
  parameter int MAX_WORDS = 16
) (
  input logic                           clk_i,
  input logic                           rst_i,
  input logic [31:0]                    os_tdata_i,
  input logic [3:0]                     os_tkeep_i,
  input logic [4:0]                     os_tuser_i,
  input logic                           os_tlast_i,
  input logic                           os_tvalid_i,
  input logic                           os_tready_i,
  input logic [31:0]                    lk_tdata_i,
  input logic [3:0]                     lk_tkeep_i,
  input logic [3:0]                     lk_tuser_i,
  input logic                           lk_tlast_i,
  input logic                           lk_tvalid_i,
  input logic                           lk_tready_i,
  input logic [$clog2(MAX_LANES+1)-1:0] num_lanes_i,
  input logic [MAX_LANES-1:0]           lane_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [$clog2(MAX_WORDS+1):0] words_r;
  logic                         os_fire;
  logic                         lk_fire;
  logic                         word_last;
  int                           fail_cnt = 0;

  assign os_fire   = os_tvalid_i && os_tready_i;
  assign lk_fire   = lk_tvalid_i && lk_tready_i;
  assign word_last = os_fire ? os_tlast_i : lk_tlast_i;

  // words accepted so far in the open packet
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      words_r <= '0;
    end else if (os_fire || lk_fire) begin
      words_r <= word_last ? '0 : words_r + 1'b1;
    end
  end

  os_held: assert property (@(posedge clk_i) disable iff (rst_i)
    os_tvalid_i && !os_tready_i |=>
      os_tvalid_i && $stable({os_tdata_i, os_tkeep_i, os_tuser_i, os_tlast_i}))
    else begin
      fail_cnt++;
      $error("ordered-set payload changed while waiting for tready");
    end

  lk_held: assert property (@(posedge clk_i) disable iff (rst_i)
    lk_tvalid_i && !lk_tready_i |=>
      lk_tvalid_i && $stable({lk_tdata_i, lk_tkeep_i, lk_tuser_i, lk_tlast_i}))
    else begin
      fail_cnt++;
      $error("link payload changed while waiting for tready");
    end

  pkt_len: assert property (@(posedge clk_i) disable iff (rst_i)
    (os_fire || lk_fire) |-> (words_r < MAX_WORDS))
    else begin
      fail_cnt++;
      $error("packet longer than %0d words", MAX_WORDS);
    end

  lanes_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    (lane_valid_i >> num_lanes_i) == '0)
    else begin
      fail_cnt++;
      $error("lane_valid_o set on a lane beyond num_lanes_i");
    end

endmodule

bind pcie_tx_lanes pcie_tx_lanes_sva #(
  .MAX_LANES(MAX_LANES),
  .MAX_WORDS(MAX_WORDS)
) pcie_tx_lanes_sva_i (
  .clk_i, .rst_i,
  .os_tdata_i, .os_tkeep_i, .os_tuser_i, .os_tlast_i, .os_tvalid_i,
  .os_tready_i(os_tready_o),
  .lk_tdata_i, .lk_tkeep_i, .lk_tuser_i, .lk_tlast_i, .lk_tvalid_i,
  .lk_tready_i(lk_tready_o),
  .num_lanes_i, .lane_valid_i(lane_valid_o)
);

`default_nettype wire

// ==== sim/pcie_tx_lanes_tb.sv ====
`default_nettype none

module pcie_tx_lanes_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import pcie_phy_pkg::*;

  localparam int LANES     = 4;
  localparam int WORDS     = 16;
  localparam int MAX_BYTES = 4 * WORDS;
  localparam int TIMEOUT   = 2000;
  localparam int NUM       = 18;

  typedef struct packed {
    logic       is_os;
    rate_e      rate;
    logic [2:0] lanes;
    logic       rev;
    logic       replace;
    logic [6:0] len;
    logic       tie;
  } entry_t;

  typedef struct packed {
    logic [LANES*32-1:0] data;
    logic [LANES*4-1:0]  k;
    logic [LANES-1:0]    valid;
    logic [LANES*2-1:0]  sync;
    logic                blk;
    logic [5:0]          width;
    logic [15:0]         pkt;
    logic [15:0]         beat;
  } beat_t;

  logic                         clk_i;
  logic                         rst_i;
  logic [31:0]                  os_tdata_i;
  logic [3:0]                   os_tkeep_i;
  logic [4:0]                   os_tuser_i;
  logic                         os_tlast_i;
  logic                         os_tvalid_i;
  logic                         os_tready_o;
  logic [31:0]                  lk_tdata_i;
  logic [3:0]                   lk_tkeep_i;
  logic [3:0]                   lk_tuser_i;
  logic                         lk_tlast_i;
  logic                         lk_tvalid_i;
  logic                         lk_tready_o;
  rate_e                        rate_i;
  logic [$clog2(LANES+1)-1:0]   num_lanes_i;
  logic                         lane_reverse_i;
  logic [31:0]                  lane_data_o [LANES];
  logic [3:0]                   lane_k_o [LANES];
  logic [LANES-1:0]             lane_valid_o;
  logic [1:0]                   sync_header_o [LANES];
  logic                         block_start_o;
  logic [5:0]                   pipe_width_o;

  integer     seed = 32'h0a0d503e;
  logic [7:0] pay_data [2][MAX_BYTES];
  logic       pay_k [2][MAX_BYTES];
  beat_t      exp_q [$];

  // stream, rate, lanes, reverse, replace, bytes, sent together with next entry
  entry_t tbl [NUM] = '{
    '{1'b0, gen1, 3'd1, 1'b0, 1'b0, 7'd13, 1'b0},
    '{1'b0, gen2, 3'd2, 1'b0, 1'b0, 7'd22, 1'b0},
    '{1'b0, gen4, 3'd4, 1'b0, 1'b0, 7'd37, 1'b0},
    '{1'b0, gen1, 3'd4, 1'b0, 1'b0, 7'd9,  1'b0},
    '{1'b0, gen4, 3'd2, 1'b0, 1'b0, 7'd64, 1'b0},
    '{1'b1, gen1, 3'd4, 1'b0, 1'b1, 7'd16, 1'b0},
    '{1'b1, gen2, 3'd4, 1'b1, 1'b1, 7'd16, 1'b0},
    '{1'b1, gen4, 3'd2, 1'b1, 1'b1, 7'd16, 1'b0},
    '{1'b1, gen2, 3'd3, 1'b1, 1'b1, 7'd8,  1'b0},
    '{1'b0, gen3, 3'd4, 1'b0, 1'b0, 7'd50, 1'b0},
    '{1'b0, gen3, 3'd1, 1'b0, 1'b0, 7'd40, 1'b0},
    '{1'b1, gen3, 3'd4, 1'b0, 1'b0, 7'd16, 1'b0},
    '{1'b0, gen5, 3'd3, 1'b0, 1'b0, 7'd61, 1'b0},
    '{1'b1, gen5, 3'd1, 1'b1, 1'b1, 7'd36, 1'b0},
    '{1'b1, gen3, 3'd4, 1'b1, 1'b1, 7'd16, 1'b1},
    '{1'b0, gen3, 3'd4, 1'b0, 1'b0, 7'd30, 1'b0},
    '{1'b1, gen1, 3'd2, 1'b0, 1'b1, 7'd16, 1'b1},
    '{1'b0, gen1, 3'd2, 1'b0, 1'b0, 7'd11, 1'b0}
  };

  pcie_tx_lanes #(
    .MAX_LANES(LANES),
    .MAX_WORDS(WORDS)
  ) pcie_tx_lanes_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", what, expected, actual);
      abort_run();
    end
  endtask

  // bytes per lane per beat at each rate
  function automatic int rate_bytes(rate_e r);
    if (r == gen1) begin
      return 1;
    end else if (r == gen2 || r == gen3) begin
      return 2;
    end
    return 4;
  endfunction

  task automatic make_payload(input int slot, input int len);
    for (int i = 0; i < len; i++) begin
      pay_data[slot][i] = 8'($random(seed));
      pay_k[slot][i]    = (($random(seed) & 3) == 0);
    end
  endtask

  // link byte k goes to lane k mod n, slot (k div n) mod w, beat k div (n*w)
  task automatic expect_packet(input int slot, input entry_t e, input int idx);
    beat_t      bt;
    int         w;
    int         n;
    int         per_beat;
    int         beats;
    int         pos;
    logic [7:0] pad;
    w        = rate_bytes(e.rate);
    n        = int'(e.lanes);
    per_beat = e.is_os ? w : n * w;
    beats    = (int'(e.len) + per_beat - 1) / per_beat;
    pad      = (e.rate >= gen3) ? PAD_BYTE_128B : 8'h00;
    for (int b = 0; b < beats; b++) begin
      bt       = '0;
      bt.pkt   = 16'(idx);
      bt.beat  = 16'(b);
      bt.width = 6'(w * 8);
      bt.blk   = (e.rate >= gen3) && ((b * w) % BLOCK_BYTES == 0);
      for (int l = 0; l < n; l++) begin
        bt.valid[l] = 1'b1;
        if (bt.blk) begin
          bt.sync[2*l+:2] = e.is_os ? SYNC_OS : SYNC_DATA;
        end
        for (int s = 0; s < 4; s++) begin
          bt.data[32*l+8*s+:8] = pad;
          pos = e.is_os ? b * w + s : (b * w + s) * n + l;
          if (s < w && pos < int'(e.len)) begin
            bt.data[32*l+8*s+:8] = pay_data[slot][pos];
            bt.k[4*l+s]          = pay_k[slot][pos];
            if (e.is_os && e.replace && pos == LANE_NUM_BYTE) begin
              bt.data[32*l+8*s+:8] = e.rev ? 8'(n - 1 - l) : 8'(l);
              bt.k[4*l+s]          = 1'b0;
            end
          end
        end
      end
      exp_q.push_back(bt);
    end
  endtask

  // returns one ns after the edge that took the word
  task automatic wait_ready(input logic is_os);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (!(is_os ? os_tready_o : lk_tready_o)) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("%s stream: tready stayed low for %0d cycles",
                 is_os ? "ordered-set" : "link", TIMEOUT);
        abort_run();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic send_packet(input int slot, input entry_t e);
    int          nwords;
    int          b;
    logic [31:0] data;
    logic [3:0]  keep;
    logic [3:0]  k;
    nwords = (int'(e.len) + 3) / 4;
    for (int wd = 0; wd < nwords; wd++) begin
      data = '0;
      keep = '0;
      k    = '0;
      for (int i = 0; i < 4; i++) begin
        b = 4 * wd + i;
        if (b < int'(e.len)) begin
          data[8*i+:8] = pay_data[slot][b];
          keep[i]      = 1'b1;
          k[i]         = pay_k[slot][b];
        end
      end
      if (e.is_os) begin
        os_tdata_i  = data;
        os_tkeep_i  = keep;
        os_tuser_i  = {(wd == 0) && e.replace, k};
        os_tlast_i  = (wd == nwords - 1);
        os_tvalid_i = 1'b1;
      end else begin
        lk_tdata_i  = data;
        lk_tkeep_i  = keep;
        lk_tuser_i  = k;
        lk_tlast_i  = (wd == nwords - 1);
        lk_tvalid_i = 1'b1;
      end
      wait_ready(e.is_os);
    end
    if (e.is_os) begin
      os_tvalid_i = 1'b0;
    end else begin
      lk_tvalid_i = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("%0d expected beats never appeared on the lanes", exp_q.size());
        abort_run();
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin : monitor
    beat_t exp;
    string tag;
    forever begin
      @(negedge clk_i);
      if (pcie_tx_lanes_i.pcie_tx_lanes_sva_i.fail_cnt != 0) begin
        $display("an assertion on the DUT ports failed");
        abort_run();
      end
      if (!rst_i && (|lane_valid_o)) begin
        if (exp_q.size() == 0) begin
          $display("lane_valid_o was set while no beat was expected");
          abort_run();
        end
        exp = exp_q.pop_front();
        tag = $sformatf("pkt %0d beat %0d", exp.pkt, exp.beat);
        check_equal({tag, " valid"}, 32'(exp.valid), 32'(lane_valid_o));
        check_equal({tag, " pipe_width"}, 32'(exp.width), 32'(pipe_width_o));
        check_equal({tag, " block_start"}, 32'(exp.blk), 32'(block_start_o));
        for (int l = 0; l < LANES; l++) begin
          check_equal($sformatf("%s lane %0d data", tag, l),
                      exp.data[32*l+:32], lane_data_o[l]);
          check_equal($sformatf("%s lane %0d k", tag, l),
                      32'(exp.k[4*l+:4]), 32'(lane_k_o[l]));
          check_equal($sformatf("%s lane %0d sync", tag, l),
                      32'(exp.sync[2*l+:2]), 32'(sync_header_o[l]));
        end
      end else if (!rst_i) begin
        check_equal("idle block_start", 32'd0, 32'(block_start_o));
      end
    end
  end

  initial begin : main
    int i;
    rst_i          = 1'b1;
    os_tdata_i     = '0;
    os_tkeep_i     = '0;
    os_tuser_i     = '0;
    os_tlast_i     = 1'b0;
    os_tvalid_i    = 1'b0;
    lk_tdata_i     = '0;
    lk_tkeep_i     = '0;
    lk_tuser_i     = '0;
    lk_tlast_i     = 1'b0;
    lk_tvalid_i    = 1'b0;
    rate_i         = gen1;
    num_lanes_i    = 1;
    lane_reverse_i = 1'b0;

    @(posedge clk_i);
    @(negedge clk_i);
    check_equal("reset os_tready", 32'd0, 32'(os_tready_o));
    check_equal("reset lk_tready", 32'd0, 32'(lk_tready_o));
    check_equal("reset lane_valid", 32'd0, 32'(lane_valid_o));
    check_equal("reset block_start", 32'd0, 32'(block_start_o));
    check_equal("reset pipe_width", 32'd8, 32'(pipe_width_o));
    @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    i = 0;
    while (i < NUM) begin
      rate_i         = tbl[i].rate;
      num_lanes_i    = tbl[i].lanes;
      lane_reverse_i = tbl[i].rev;
      make_payload(0, int'(tbl[i].len));
      expect_packet(0, tbl[i], i);
      if (tbl[i].tie) begin
        // both streams valid in the same cycle so the ordered set goes first
        make_payload(1, int'(tbl[i+1].len));
        expect_packet(1, tbl[i+1], i + 1);
        fork
          send_packet(0, tbl[i]);
          send_packet(1, tbl[i+1]);
        join
        i = i + 2;
      end else begin
        send_packet(0, tbl[i]);
        i = i + 1;
      end
      wait_drain();
    end

    if (pcie_tx_lanes_i.pcie_tx_lanes_sva_i.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== pcie_tx_lanes.f ====
verilog/pcie_phy_pkg.sv
verilog/tx_stream_select.sv
verilog/lane_management.sv
verilog/lane_tx_output.sv
verilog/pcie_tx_lanes.sv
sim/pcie_tx_lanes_sva.sv
sim/pcie_tx_lanes_tb.sv
